//--- source/tm1638_params.svh
`ifndef TM1638_PARAMS_SVH
`define TM1638_PARAMS_SVH

// command bytes sent each frame
`define TM_CMD_DATA_WRITE 8'h40  // write, auto increment
`define TM_CMD_ADDR0      8'hC0  // display ram from address 0
`define TM_CMD_BRIGHT     8'h8F  // display on, brightest
`define TM_CMD_KEY_READ   8'h42

// board layout
`define TM_DIGITS    8
`define TM_KEY_BYTES 4  // read bytes per key scan

// clk cycles per half serial period
`define TM_HALF_DIV_DEFAULT 24

// serial periods between refreshes
`define TM_FRAME_SCLKS_DEFAULT 4000

`endif

//--- source/tm1638_pkg.sv
`include "tm1638_params.svh"

package tm1638_pkg;

    // display contents, digit 0 in the low bits of each field
    typedef struct packed {
        logic [4*`TM_DIGITS-1:0] digits;
        logic [`TM_DIGITS-1:0]   blank;  // 1 turns the digit dark
        logic [`TM_DIGITS-1:0]   dots;
        logic [`TM_DIGITS-1:0]   leds;
    } disp_frame_t;

    // one byte on the serial link
    typedef struct packed {
        logic [7:0] data;
        logic       rd;     // read, driver off
        logic       first;  // strobe low before
        logic       last;   // strobe high after
    } byte_req_t;

    // hex font, gfedcba
    function automatic logic [6:0] seg_font(input logic [3:0] nib);
        logic [6:0] seg;
        case (nib)
            4'h0: seg = 7'h3F;
            4'h1: seg = 7'h06;
            4'h2: seg = 7'h5B;
            4'h3: seg = 7'h4F;
            4'h4: seg = 7'h66;
            4'h5: seg = 7'h6D;
            4'h6: seg = 7'h7D;
            4'h7: seg = 7'h27;
            4'h8: seg = 7'h7F;
            4'h9: seg = 7'h6F;
            4'hA: seg = 7'h77;
            4'hB: seg = 7'h7C;  // lower case b
            4'hC: seg = 7'h39;
            4'hD: seg = 7'h5E;  // lower case d
            4'hE: seg = 7'h79;
            default: seg = 7'h71;
        endcase
        return seg;
    endfunction

endpackage

//--- source/tm1638_tick_gen.sv
`timescale 1ns/1ns
`include "tm1638_params.svh"

module tm1638_tick_gen #(
    parameter int HALF_DIV    = `TM_HALF_DIV_DEFAULT,
    parameter int FRAME_SCLKS = `TM_FRAME_SCLKS_DEFAULT
) (
    input  logic clk,
    input  logic n_rst,
    output logic sclk_fall_o,
    output logic sclk_rise_o,
    output logic frame_start_o
);
    localparam int HW = $clog2(HALF_DIV + 1);
    localparam int FW = $clog2(FRAME_SCLKS + 1);

    logic [HW-1:0] half_cnt;
    logic          phase;  // 0 means next edge is a fall
    logic [FW-1:0] frame_cnt;
    logic          half_wrap;
    logic          frame_wrap;

    assign half_wrap  = (half_cnt == HW'(HALF_DIV - 1));
    assign frame_wrap = (frame_cnt == FW'(FRAME_SCLKS - 1));

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            half_cnt      <= '0;
            phase         <= 1'b0;
            frame_cnt     <= '0;
            sclk_fall_o   <= 1'b0;
            sclk_rise_o   <= 1'b0;
            frame_start_o <= 1'b0;
        end else begin
            sclk_fall_o   <= half_wrap & ~phase;
            sclk_rise_o   <= half_wrap & phase;
            frame_start_o <= half_wrap & ~phase & frame_wrap;  // lands on a fall
            if (half_wrap) begin
                half_cnt <= '0;
                phase    <= ~phase;
            end else begin
                half_cnt <= half_cnt + 1'b1;
            end
            if (half_wrap && !phase) begin
                frame_cnt <= frame_wrap ? '0 : frame_cnt + 1'b1;
            end
        end
    end

    // each rise comes half a serial period after its fall
    a_edges_apart: assert property (
        @(posedge clk) disable iff (!n_rst)
        sclk_rise_o |-> !sclk_fall_o && $past(sclk_fall_o, HALF_DIV)
    );

endmodule

//--- source/tm1638_byte_shifter.sv
`timescale 1ns/1ns

module tm1638_byte_shifter (
    input  logic                  clk,
    input  logic                  n_rst,
    input  logic                  sclk_fall_i,
    input  logic                  sclk_rise_i,
    input  logic                  start_i,
    input  logic                  dio_i,
    input  tm1638_pkg::byte_req_t req_i,
    output logic                  done_o,
    output logic [7:0]            rx_byte_o,
    output logic                  tm_clk_o,
    output logic                  tm_stb_o,
    output logic                  tm_dio_o,
    output logic                  tm_dio_oe_o
);
    localparam logic [3:0] STEP_QUIET = 4'd9;  // after bit 7

    logic                  busy;
    logic [3:0]            step;  // 0 strobe, 1..8 bits, 9 quiet, 10 done
    tm1638_pkg::byte_req_t req_q;
    logic                  bit_fall;
    logic                  bit_rise;

    assign bit_fall = busy && sclk_fall_i && (step != 4'd0) && (step <= 4'd8);
    assign bit_rise = busy && sclk_rise_i && !tm_clk_o;

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            busy        <= 1'b0;
            step        <= '0;
            done_o      <= 1'b0;
            tm_clk_o    <= 1'b1;
            tm_stb_o    <= 1'b1;
            tm_dio_o    <= 1'b0;
            tm_dio_oe_o <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (!busy) begin
                if (start_i) begin
                    busy <= 1'b1;
                    step <= '0;
                end
            end else if (sclk_fall_i) begin
                step <= step + 4'd1;
                if (step == 4'd0) begin
                    if (req_q.first) begin
                        tm_stb_o <= 1'b0;
                    end
                end else if (bit_fall) begin
                    tm_clk_o    <= 1'b0;
                    tm_dio_o    <= req_q.data[0];  // lsb first
                    tm_dio_oe_o <= !req_q.rd;
                end else if (step == STEP_QUIET) begin
                    tm_dio_o    <= 1'b0;
                    tm_dio_oe_o <= 1'b0;
                    if (req_q.last) begin
                        tm_stb_o <= 1'b1;
                    end
                end else begin
                    busy   <= 1'b0;
                    done_o <= 1'b1;
                end
            end else if (bit_rise) begin
                tm_clk_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && start_i) begin
            req_q <= req_i;
        end else if (bit_fall) begin
            req_q.data <= {1'b0, req_q.data[7:1]};
        end
        if (bit_rise && req_q.rd) begin
            rx_byte_o <= {dio_i, rx_byte_o[7:1]};  // chip drives on falling clk
        end
    end

    // sequencer waits for done before the next request
    a_no_start_busy: assert property (
        @(posedge clk) disable iff (!n_rst)
        start_i |-> !busy
    );

    a_read_no_drive: assert property (
        @(posedge clk) disable iff (!n_rst)
        (busy && req_q.rd) |-> !tm_dio_oe_o
    );

    a_clk_high_idle: assert property (
        @(posedge clk) disable iff (!n_rst)
        tm_stb_o |-> tm_clk_o
    );

endmodule

//--- source/tm1638_frame_seq.sv
`timescale 1ns/1ns
`include "tm1638_params.svh"

module tm1638_frame_seq (
    input  logic                    clk,
    input  logic                    n_rst,
    input  logic                    frame_start_i,
    input  logic                    done_i,
    input  logic [7:0]              rx_byte_i,
    input  tm1638_pkg::disp_frame_t frame_i,
    output tm1638_pkg::byte_req_t   req_o,
    output logic                    start_o,
    output logic                    frame_done_o,
    output logic [7:0]              keys_o
);
    // byte order within one frame
    localparam int IDX_ADDR   = 1;
    localparam int IDX_DISP0  = 2;
    localparam int IDX_BRIGHT = IDX_DISP0 + 2 * `TM_DIGITS;
    localparam int IDX_KEYCMD = IDX_BRIGHT + 1;
    localparam int IDX_RD0    = IDX_KEYCMD + 1;
    localparam int IDX_LAST   = IDX_RD0 + `TM_KEY_BYTES - 1;
    localparam int DW         = $clog2(`TM_DIGITS);

    logic                    running;
    logic [4:0]              idx;
    tm1638_pkg::disp_frame_t frame_q;
    logic [4:0]              disp_addr;
    logic [DW-1:0]           digit;
    logic [4:0]              rd_off;
    logic [2:0]              key_hi;  // key from bit 0
    logic [7:0]              key_sh;
    logic [7:0]              key_next;

    assign disp_addr = idx - 5'(IDX_DISP0);
    assign digit     = disp_addr[DW:1];
    assign rd_off    = idx - 5'(IDX_RD0);
    assign key_hi    = 3'd7 - {rd_off[1:0], 1'b0};

    always_comb begin
        req_o.data  = 8'h00;
        req_o.rd    = 1'b0;
        req_o.first = 1'b0;
        req_o.last  = 1'b0;
        if (idx == 5'd0) begin
            req_o.data  = `TM_CMD_DATA_WRITE;
            req_o.first = 1'b1;
            req_o.last  = 1'b1;
        end else if (idx == 5'(IDX_ADDR)) begin
            req_o.data  = `TM_CMD_ADDR0;
            req_o.first = 1'b1;
        end else if (idx < 5'(IDX_BRIGHT)) begin
            if (disp_addr[0]) begin
                req_o.data[0] = frame_q.leds[digit];  // odd address holds the led
            end else begin
                req_o.data[7] = frame_q.dots[digit];
                if (!frame_q.blank[digit]) begin
                    req_o.data[6:0] = tm1638_pkg::seg_font(frame_q.digits[4*digit +: 4]);
                end
            end
            req_o.last = (idx == 5'(IDX_BRIGHT - 1));
        end else if (idx == 5'(IDX_BRIGHT)) begin
            req_o.data  = `TM_CMD_BRIGHT;
            req_o.first = 1'b1;
            req_o.last  = 1'b1;
        end else if (idx == 5'(IDX_KEYCMD)) begin
            req_o.data  = `TM_CMD_KEY_READ;
            req_o.first = 1'b1;
        end else begin
            req_o.rd   = 1'b1;
            req_o.last = (idx == 5'(IDX_LAST));
        end
    end

    // two keys per read byte, bits 0 and 4
    always_comb begin
        key_next                = key_sh;
        key_next[key_hi]        = rx_byte_i[0];
        key_next[key_hi - 3'd1] = rx_byte_i[4];
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            running      <= 1'b0;
            idx          <= '0;
            start_o      <= 1'b0;
            frame_done_o <= 1'b0;
            keys_o       <= '0;
        end else begin
            start_o      <= 1'b0;
            frame_done_o <= 1'b0;
            if (!running) begin
                if (frame_start_i) begin
                    running <= 1'b1;
                    idx     <= '0;
                    start_o <= 1'b1;
                end
            end else if (done_i) begin
                if (idx == 5'(IDX_LAST)) begin
                    running      <= 1'b0;
                    frame_done_o <= 1'b1;
                    keys_o       <= key_next;
                end else begin
                    idx     <= idx + 5'd1;
                    start_o <= 1'b1;  // shifter is idle again
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!running && frame_start_i) begin
            frame_q <= frame_i;  // held for the whole frame
        end
        if (running && done_i && req_o.rd) begin
            key_sh <= key_next;
        end
    end

    // shifter only answers requests made by this frame
    a_done_in_frame: assert property (
        @(posedge clk) disable iff (!n_rst)
        done_i |-> running
    );

endmodule

//--- source/tm1638_drv.sv
`timescale 1ns/1ns
`include "tm1638_params.svh"

module tm1638_drv #(
    parameter int HALF_DIV    = `TM_HALF_DIV_DEFAULT,
    parameter int FRAME_SCLKS = `TM_FRAME_SCLKS_DEFAULT
) (
    input  logic                    clk,
    input  logic                    n_rst,
    input  tm1638_pkg::disp_frame_t frame_i,
    input  logic                    dio_i,
    output logic                    tm_clk_o,
    output logic                    tm_stb_o,
    output logic                    tm_dio_o,
    output logic                    tm_dio_oe_o,
    output logic [7:0]              keys_o,
    output logic                    frame_done_o
);
    logic                  sclk_fall;
    logic                  sclk_rise;
    logic                  frame_start;
    tm1638_pkg::byte_req_t req;
    logic                  start;
    logic                  done;
    logic [7:0]            rx_byte;

    tm1638_tick_gen #(
        .HALF_DIV    (HALF_DIV),
        .FRAME_SCLKS (FRAME_SCLKS)
    ) tick_gen_i (
        .clk           (clk),
        .n_rst         (n_rst),
        .sclk_fall_o   (sclk_fall),
        .sclk_rise_o   (sclk_rise),
        .frame_start_o (frame_start)
    );

    tm1638_frame_seq frame_seq_i (
        .clk           (clk),
        .n_rst         (n_rst),
        .frame_start_i (frame_start),
        .done_i        (done),
        .rx_byte_i     (rx_byte),
        .frame_i       (frame_i),
        .req_o         (req),
        .start_o       (start),
        .frame_done_o  (frame_done_o),
        .keys_o        (keys_o)
    );

    tm1638_byte_shifter byte_shifter_i (
        .clk         (clk),
        .n_rst       (n_rst),
        .sclk_fall_i (sclk_fall),
        .sclk_rise_i (sclk_rise),
        .start_i     (start),
        .dio_i       (dio_i),
        .req_i       (req),
        .done_o      (done),
        .rx_byte_o   (rx_byte),
        .tm_clk_o    (tm_clk_o),
        .tm_stb_o    (tm_stb_o),
        .tm_dio_o    (tm_dio_o),
        .tm_dio_oe_o (tm_dio_oe_o)
    );

endmodule

//--- bench/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

//--- bench/tm1638_model.sv
`timescale 1ns/1ns

module tm1638_model (
    input  logic       clk,
    input  logic       n_rst,
    input  logic       clear_i,
    input  logic [7:0] key_pattern_i,
    input  logic       tm_clk_i,
    input  logic       tm_stb_i,
    input  logic       tm_dio_i,
    input  logic       tm_dio_oe_i,
    output logic       dio_o
);
    localparam int MAX_GROUPS = 8;
    localparam int MAX_BYTES  = 24;

    // one entry per strobe group
    logic [7:0] group_byte [0:MAX_GROUPS-1][0:MAX_BYTES-1];
    int         group_len [0:MAX_GROUPS-1];
    int         group_cnt;

    logic       clk_q;
    logic       stb_q;
    logic [2:0] bit_cnt;
    logic [7:0] shift;
    int         byte_cnt;  // bytes seen in the open group
    logic       reading;   // key read command seen
    logic [7:0] byte_next;
    logic [7:0] rd_cur;

    // keys 7-2b and 6-2b sit in bits 0 and 4 of read byte b
    function automatic logic [7:0] read_byte(input logic [7:0] keys, input int b);
        logic [7:0] rb;
        rb = 8'h00;
        if (b >= 0 && b < 4) begin
            rb[0] = keys[7 - 2 * b];
            rb[4] = keys[6 - 2 * b];
        end
        return rb;
    endfunction

    always @(negedge clk or negedge n_rst) begin
        if (!n_rst) begin
            clk_q     <= 1'b1;
            stb_q     <= 1'b1;
            bit_cnt   <= '0;
            shift     <= '0;
            byte_cnt  <= 0;
            reading   <= 1'b0;
            group_cnt <= 0;
            dio_o     <= 1'b0;
        end else begin
            clk_q <= tm_clk_i;
            stb_q <= tm_stb_i;
            if (clear_i) begin
                group_cnt <= 0;
            end
            if (stb_q && !tm_stb_i) begin  // group opens
                bit_cnt  <= '0;
                byte_cnt <= 0;
                reading  <= 1'b0;
            end else if (!stb_q && tm_stb_i) begin
                if (group_cnt < MAX_GROUPS) begin
                    group_len[group_cnt] <= byte_cnt;
                    group_cnt            <= group_cnt + 1;
                end
                dio_o <= 1'b0;
            end else if (!tm_stb_i) begin
                if (clk_q && !tm_clk_i && reading) begin
                    rd_cur = read_byte(key_pattern_i, byte_cnt - 1);
                    dio_o <= rd_cur[bit_cnt];  // chip answers on falling clk
                end
                if (!clk_q && tm_clk_i) begin
                    // line is pulled high when the driver is off
                    byte_next = {reading ? dio_o : (tm_dio_oe_i ? tm_dio_i : 1'b1), shift[7:1]};
                    shift   <= byte_next;
                    bit_cnt <= bit_cnt + 3'd1;
                    if (bit_cnt == 3'd7) begin
                        if (group_cnt < MAX_GROUPS && byte_cnt < MAX_BYTES) begin
                            group_byte[group_cnt][byte_cnt] <= byte_next;
                        end
                        byte_cnt <= byte_cnt + 1;
                        if (byte_cnt == 0 && byte_next == 8'h42) begin
                            reading <= 1'b1;
                        end
                    end
                end
            end
        end
    end

endmodule

//--- bench/tb_tm1638_drv.sv
`timescale 1ns/1ns

module tb_tm1638_drv;
    logic                    clk;
    logic                    n_rst;
    tm1638_pkg::disp_frame_t frame;
    tm1638_pkg::disp_frame_t last_frame;
    logic                    dio;
    logic                    tm_clk;
    logic                    tm_stb;
    logic                    tm_dio;
    logic                    tm_dio_oe;
    logic [7:0]              keys;
    logic                    frame_done;
    logic                    clear;
    logic [7:0]              key_pattern;

    // gfedcba segments for 0 through F
    logic [6:0] font [0:15] = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h27,
                                7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71};

    tb_clk_gen clk_gen_i (.clk(clk));

    tm1638_drv #(.HALF_DIV(2), .FRAME_SCLKS(400)) tm1638_drv_i (
        .clk(clk), .n_rst(n_rst), .frame_i(frame), .dio_i(dio),
        .tm_clk_o(tm_clk), .tm_stb_o(tm_stb), .tm_dio_o(tm_dio), .tm_dio_oe_o(tm_dio_oe),
        .keys_o(keys), .frame_done_o(frame_done)
    );

    tm1638_model model_i (
        .clk(clk), .n_rst(n_rst), .clear_i(clear), .key_pattern_i(key_pattern),
        .tm_clk_i(tm_clk), .tm_stb_i(tm_stb), .tm_dio_i(tm_dio), .tm_dio_oe_i(tm_dio_oe),
        .dio_o(dio)
    );

    task automatic stop_run();
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_keys(input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("[FAIL] keys_o got %h expected %h", got, exp);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic wait_frame_done(input int limit);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > limit) begin
                $display("frame_done_o did not pulse within %0d cycles", limit);
                stop_run();
            end
        end while (frame_done !== 1'b1);
    endtask

    task automatic wait_strobe_low(input int limit);
        int n;
        n = 0;
        while (tm_stb !== 1'b0) begin
            @(negedge clk);
            n++;
            if (n > limit) begin
                $display("strobe never went low within %0d cycles", limit);
                stop_run();
            end
        end
    endtask

    task automatic clear_record();
        clear <= 1'b1;
        @(negedge clk);
        clear <= 1'b0;
        @(negedge clk);
    endtask

    function automatic logic [7:0] expected_disp(input tm1638_pkg::disp_frame_t f, input int addr);
        int         k;
        logic [7:0] b;
        k = addr / 2;
        b = 8'h00;
        if (addr % 2 == 1) begin
            b[0] = f.leds[k];
        end else begin
            b[7] = f.dots[k];
            if (!f.blank[k]) begin
                b[6:0] = font[f.digits[4*k +: 4]];
            end
        end
        return b;
    endfunction

    task automatic check_display(input tm1638_pkg::disp_frame_t f);
        int a;
        check_byte("display group length", 8'(model_i.group_len[1]), 8'd17);
        for (a = 0; a < 16; a++) begin
            check_byte($sformatf("display byte %0d", a), model_i.group_byte[1][a + 1],
                       expected_disp(f, a));
        end
    endtask

    task automatic check_group(input int g, input int len, input logic [7:0] head);
        check_byte($sformatf("group %0d length", g), 8'(model_i.group_len[g]), 8'(len));
        check_byte($sformatf("group %0d command", g), model_i.group_byte[g][0], head);
    endtask

    function automatic tm1638_pkg::disp_frame_t random_frame();
        tm1638_pkg::disp_frame_t f;
        f.digits = $urandom;
        f.blank  = 8'h00;
        f.dots   = 8'($urandom);
        f.leds   = 8'($urandom);
        return f;
    endfunction

    task automatic idle_after_reset();
        check_bit("tm_stb_o", tm_stb, 1'b1);
        check_bit("tm_clk_o", tm_clk, 1'b1);
        check_bit("tm_dio_oe_o", tm_dio_oe, 1'b0);
        check_bit("tm_dio_o", tm_dio, 1'b0);
        check_bit("frame_done_o", frame_done, 1'b0);
        check_keys(keys, 8'h00);
    endtask

    task automatic frame_structure();
        clear_record();
        wait_frame_done(4000);
        check_byte("group count", 8'(model_i.group_cnt), 8'd4);
        check_group(0, 1, 8'h40);
        check_group(1, 17, 8'hC0);
        check_group(2, 1, 8'h8F);
        check_group(3, 5, 8'h42);
        repeat (20) begin
            @(negedge clk);
            check_bit("frame_done_o", frame_done, 1'b0);  // single pulse
        end
    endtask

    task automatic display_content();
        last_frame = random_frame();
        frame <= last_frame;
        clear_record();
        wait_frame_done(4000);
        check_display(last_frame);
    endtask

    task automatic blank_digits();
        last_frame.blank = 8'($urandom) | 8'h01;
        frame <= last_frame;
        clear_record();
        wait_frame_done(4000);
        check_display(last_frame);
    endtask

    task automatic key_readback();
        logic [7:0] pattern;
        pattern = 8'($urandom);
        key_pattern <= pattern;
        clear_record();
        wait_frame_done(4000);
        check_keys(keys, pattern);
    endtask

    task automatic mid_frame_update();
        tm1638_pkg::disp_frame_t fa;
        tm1638_pkg::disp_frame_t fb;
        fa = random_frame();
        fb = random_frame();
        fb.digits = ~fa.digits;  // new frame must differ
        frame <= fa;
        clear_record();
        wait_strobe_low(3000);
        frame <= fb;
        wait_frame_done(4000);
        check_display(fa);
        clear_record();
        wait_frame_done(4000);
        check_display(fb);
    endtask

    initial begin
        void'($urandom(58054));
        n_rst       = 1'b0;
        frame       = '0;
        clear       = 1'b0;
        key_pattern = 8'h00;
        repeat (8) @(negedge clk);
        n_rst <= 1'b1;
        @(negedge clk);
        idle_after_reset();
        frame_structure();
        display_content();
        blank_digits();
        key_readback();
        mid_frame_update();
        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+source
source/tm1638_pkg.sv
source/tm1638_tick_gen.sv
source/tm1638_byte_shifter.sv
source/tm1638_frame_seq.sv
source/tm1638_drv.sv
bench/tb_clk_gen.sv
bench/tm1638_model.sv
bench/tb_tm1638_drv.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_tm1638_drv \
    -f vlog.f -Mdir obj_dir

out=$(./obj_dir/Vtb_tm1638_drv || true)
echo "$out"
echo "$out" | grep -q "TEST PASSED"
